// File: compile.f
logic/kbd_pkg.sv
logic/ps2_frame_rx.sv
logic/scan_tracker.sv
logic/ascii_queue.sv
logic/ps2_keyboard.sv
sim/ps2_keyboard_properties.sv
sim/ps2_keyboard_tb.sv

// File: logic/ascii_queue.sv
`timescale 1ns/1ps

module ascii_queue (
	input  logic                clk,
	input  logic                rstn,
	input  logic                ev_valid,
	input  kbd_pkg::key_event_t ev,
	input  logic                out_ready,
	output logic                out_valid,
	output kbd_pkg::ascii_t     out_char,
	output logic                overflow
);

	kbd_pkg::ascii_t map_char;
	logic mapped;
	kbd_pkg::ascii_t mem [kbd_pkg::queue_depth];
	logic [kbd_pkg::queue_ptr_w-1:0] wr_ptr;
	logic [kbd_pkg::queue_ptr_w-1:0] rd_ptr;
	logic [kbd_pkg::queue_ptr_w:0] count;
	logic full;
	logic push;
	logic pop;

	always_comb begin
		map_char = '0;
		mapped   = 1'b1;
		if (ev.extended) begin
			case (ev.code)
				kbd_pkg::code_up:    map_char = kbd_pkg::ascii_up;
				kbd_pkg::code_down:  map_char = kbd_pkg::ascii_down;
				kbd_pkg::code_left:  map_char = kbd_pkg::ascii_left;
				kbd_pkg::code_right: map_char = kbd_pkg::ascii_right;
				default:             mapped = 1'b0;
			endcase
		end else begin
			case (ev.code)
				8'h1C: map_char = "a";
				8'h32: map_char = "b";
				8'h21: map_char = "c";
				8'h23: map_char = "d";
				8'h24: map_char = "e";
				8'h2B: map_char = "f";
				8'h34: map_char = "g";
				8'h33: map_char = "h";
				8'h43: map_char = "i";
				8'h3B: map_char = "j";
				8'h42: map_char = "k";
				8'h4B: map_char = "l";
				8'h3A: map_char = "m";
				8'h31: map_char = "n";
				8'h44: map_char = "o";
				8'h4D: map_char = "p";
				8'h15: map_char = "q";
				8'h2D: map_char = "r";
				8'h1B: map_char = "s";
				8'h2C: map_char = "t";
				8'h3C: map_char = "u";
				8'h2A: map_char = "v";
				8'h1D: map_char = "w";
				8'h22: map_char = "x";
				8'h35: map_char = "y";
				8'h1A: map_char = "z";
				8'h16: map_char = ev.shift ? "!" : "1";
				8'h1E: map_char = ev.shift ? "@" : "2";
				8'h26: map_char = ev.shift ? "#" : "3";
				8'h25: map_char = ev.shift ? "$" : "4";
				8'h2E: map_char = ev.shift ? "%" : "5";
				8'h36: map_char = ev.shift ? "^" : "6";
				8'h3D: map_char = ev.shift ? "&" : "7";
				8'h3E: map_char = ev.shift ? "*" : "8";
				8'h46: map_char = ev.shift ? "(" : "9";
				8'h45: map_char = ev.shift ? ")" : "0";
				8'h29: map_char = " ";
				8'h5A: map_char = 8'h0D; // enter as carriage return
				default: mapped = 1'b0;
			endcase
			if (ev.shift && map_char >= "a" && map_char <= "z") begin
				map_char = map_char - 8'h20; // to upper case
			end
		end
	end

	assign full = count == (kbd_pkg::queue_ptr_w + 1)'(kbd_pkg::queue_depth);
	assign push = ev_valid && mapped && !full;
	assign out_valid = count != '0;
	assign pop = out_valid && out_ready;
	assign out_char = out_valid ? mem[rd_ptr] : '0;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= map_char;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			overflow <= ev_valid && mapped && full; // char dropped
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/kbd_pkg.sv
package kbd_pkg;

	typedef logic [7:0] scan_code_t;
	typedef logic [7:0] ascii_t;

	// set-2 prefixes
	localparam scan_code_t code_ext = 8'hE0;
	localparam scan_code_t code_brk = 8'hF0;

	localparam scan_code_t code_lshift = 8'h12;
	localparam scan_code_t code_rshift = 8'h59;

	// arrows, only valid after code_ext
	localparam scan_code_t code_up    = 8'h75;
	localparam scan_code_t code_down  = 8'h72;
	localparam scan_code_t code_left  = 8'h6B;
	localparam scan_code_t code_right = 8'h74;

	localparam ascii_t ascii_up    = 8'h01;
	localparam ascii_t ascii_down  = 8'h02;
	localparam ascii_t ascii_left  = 8'h03;
	localparam ascii_t ascii_right = 8'h04;

	typedef struct packed {
		scan_code_t code;
		logic       extended;
		logic       shift; // shift held at press time
	} key_event_t;

	localparam int queue_depth = 8;
	localparam int queue_ptr_w = 3;

	typedef enum logic [1:0] {
		rx_idle,
		rx_data,
		rx_parity,
		rx_stop
	} rx_state_e;

	typedef enum logic [1:0] {
		trk_base,
		trk_ext,
		trk_brk,
		trk_ext_brk
	} trk_state_e;

endpackage

// File: logic/ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx (
	input  logic                clk,
	input  logic                rstn,
	input  logic                ps2_clk,
	input  logic                ps2_dat,
	output logic                byte_valid,
	output kbd_pkg::scan_code_t byte_data,
	output logic                frame_error
);

	logic [1:0] clk_sync;
	logic [1:0] dat_sync;
	logic clk_prev;
	logic fall;
	logic frame_ok;
	logic start_q;
	logic parity_q;
	logic [2:0] bit_cnt;
	kbd_pkg::rx_state_e state;
	kbd_pkg::scan_code_t shift_q;

	// lines idle high
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			dat_sync <= {dat_sync[0], ps2_dat};
			clk_prev <= clk_sync[1];
		end
	end

	assign fall = clk_prev & ~clk_sync[1];

	// checked while the stop bit is on dat_sync
	assign frame_ok = ~start_q & dat_sync[1] & (^{shift_q, parity_q});

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= kbd_pkg::rx_idle;
			bit_cnt     <= '0;
			start_q     <= 1'b0;
			parity_q    <= 1'b0;
			byte_valid  <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			byte_valid  <= 1'b0;
			frame_error <= 1'b0;
			if (fall) begin
				case (state)
					kbd_pkg::rx_idle: begin
						start_q <= dat_sync[1]; // judged at the stop bit
						bit_cnt <= '0;
						state   <= kbd_pkg::rx_data;
					end
					kbd_pkg::rx_data: begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= kbd_pkg::rx_parity;
						end
					end
					kbd_pkg::rx_parity: begin
						parity_q <= dat_sync[1];
						state    <= kbd_pkg::rx_stop;
					end
					kbd_pkg::rx_stop: begin
						byte_valid  <= frame_ok;
						frame_error <= ~frame_ok;
						state       <= kbd_pkg::rx_idle;
					end
					default: begin
						state <= kbd_pkg::rx_idle;
					end
				endcase
			end
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (fall && state == kbd_pkg::rx_data) begin
			shift_q <= {dat_sync[1], shift_q[7:1]};
		end
	end

	assign byte_data = shift_q; // stable until next frame's data bits

endmodule

// File: logic/ps2_keyboard.sv
`timescale 1ns/1ps

module ps2_keyboard (
	input  logic            clk,
	input  logic            rstn,
	input  logic            ps2_clk,
	input  logic            ps2_dat,
	input  logic            out_ready,
	output logic            out_valid,
	output kbd_pkg::ascii_t out_char,
	output logic            frame_error,
	output logic            overflow
);

	logic byte_valid;
	kbd_pkg::scan_code_t byte_data;
	logic ev_valid;
	kbd_pkg::key_event_t ev;

	ps2_frame_rx u_rx (
		.clk         (clk),
		.rstn        (rstn),
		.ps2_clk     (ps2_clk),
		.ps2_dat     (ps2_dat),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.frame_error (frame_error)
	);

	scan_tracker u_trk (
		.clk        (clk),
		.rstn       (rstn),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.ev_valid   (ev_valid),
		.ev         (ev)
	);

	ascii_queue u_queue (
		.clk       (clk),
		.rstn      (rstn),
		.ev_valid  (ev_valid),
		.ev        (ev),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.out_char  (out_char),
		.overflow  (overflow)
	);

endmodule

// File: logic/scan_tracker.sv
`timescale 1ns/1ps

module scan_tracker (
	input  logic                clk,
	input  logic                rstn,
	input  logic                byte_valid,
	input  kbd_pkg::scan_code_t byte_data,
	output logic                ev_valid,
	output kbd_pkg::key_event_t ev
);

	kbd_pkg::trk_state_e state;
	kbd_pkg::scan_code_t last_code;
	logic last_ext;
	logic last_valid;
	logic [1:0] shift_held; // left, right
	logic is_ext;
	logic is_brk;
	logic is_prefix;
	logic is_lshift;
	logic is_rshift;
	logic is_repeat;
	logic new_press;

	assign is_ext = (state == kbd_pkg::trk_ext) || (state == kbd_pkg::trk_ext_brk);
	assign is_brk = (state == kbd_pkg::trk_brk) || (state == kbd_pkg::trk_ext_brk);

	assign is_prefix = (byte_data == kbd_pkg::code_ext) || (byte_data == kbd_pkg::code_brk);
	assign is_lshift = !is_ext && (byte_data == kbd_pkg::code_lshift);
	assign is_rshift = !is_ext && (byte_data == kbd_pkg::code_rshift);

	// same key still down, so a typematic repeat
	assign is_repeat = last_valid && (last_code == byte_data) && (last_ext == is_ext);

	assign new_press = byte_valid && !is_prefix && !is_brk && !is_lshift && !is_rshift
		&& !is_repeat;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= kbd_pkg::trk_base;
			shift_held <= 2'b00;
			last_valid <= 1'b0;
			ev_valid   <= 1'b0;
		end else begin
			ev_valid <= new_press;
			if (byte_valid) begin
				if (byte_data == kbd_pkg::code_ext) begin
					state <= kbd_pkg::trk_ext;
				end else if (byte_data == kbd_pkg::code_brk) begin
					state <= is_ext ? kbd_pkg::trk_ext_brk : kbd_pkg::trk_brk;
				end else begin
					state <= kbd_pkg::trk_base;
					if (is_lshift) begin
						shift_held[0] <= !is_brk;
					end else if (is_rshift) begin
						shift_held[1] <= !is_brk;
					end else if (is_brk) begin
						if (is_repeat) begin
							last_valid <= 1'b0; // held key released
						end
					end else begin
						last_valid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (new_press) begin
			ev.code     <= byte_data;
			ev.extended <= is_ext;
			ev.shift    <= |shift_held;
			last_code   <= byte_data;
			last_ext    <= is_ext;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator and run; result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module ps2_keyboard_tb -o ps2_keyboard_sim || { echo "build failed"; exit 1; }
./obj_dir/ps2_keyboard_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "test failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "simulation ended early"; exit 1; }
echo "test passed"

// File: sim/ps2_keyboard_properties.sv
`timescale 1ns/1ps

module ps2_keyboard_properties (
	input logic            clk,
	input logic            rstn,
	input logic            out_valid,
	input logic            out_ready,
	input kbd_pkg::ascii_t out_char,
	input logic            frame_error,
	input logic            overflow
);

	int fail_count = 0;

	char_stable: assert property (@(posedge clk) disable iff (!rstn)
		out_valid && !out_ready |=> $stable(out_char))
		else begin
			fail_count++;
			$error("out_char changed while stalled");
		end

	outputs_known: assert property (@(posedge clk) disable iff (!rstn)
		!$isunknown({out_valid, out_char, frame_error, overflow}))
		else begin
			fail_count++;
			$error("unknown value on an output");
		end

	ferr_single: assert property (@(posedge clk) disable iff (!rstn)
		frame_error |=> !frame_error)
		else begin
			fail_count++;
			$error("frame_error high two cycles in a row");
		end

	ovf_single: assert property (@(posedge clk) disable iff (!rstn)
		overflow |=> !overflow)
		else begin
			fail_count++;
			$error("overflow high two cycles in a row");
		end

endmodule

bind ps2_keyboard ps2_keyboard_properties u_props (
	.clk         (clk),
	.rstn        (rstn),
	.out_valid   (out_valid),
	.out_ready   (out_ready),
	.out_char    (out_char),
	.frame_error (frame_error),
	.overflow    (overflow)
);

// File: sim/ps2_keyboard_tb.sv
`timescale 1ns/1ps

module ps2_keyboard_tb;

	localparam logic [31:0] seed = 32'h65b0_2716;
	localparam int num_steps = 20;
	localparam int char_timeout = 200;
	localparam int quiet_cycles = 40;

	typedef struct packed {
		logic [95:0] seq;   // last byte in bits 7:0
		logic [3:0]  len;
		logic [11:0] bad;   // bit i flips parity of byte i
		logic [15:0] chars; // last char in bits 7:0
		logic [1:0]  n_chars;
		logic [1:0]  n_ferr;
		logic [1:0]  n_ovf;
		logic        hold;  // out_ready forced low
	} step_t;

	logic clk = 1'b0;
	logic rstn;
	logic ps2_clk;
	logic ps2_dat;
	logic out_ready = 1'b0;
	logic out_valid;
	kbd_pkg::ascii_t out_char;
	logic frame_error;
	logic overflow;

	step_t steps [num_steps];
	kbd_pkg::ascii_t got_q [$];
	logic hold_ready = 1'b1;
	logic [31:0] rdy_rng = seed;
	logic [31:0] gap_rng = seed;
	int ferr_cnt = 0;
	int ovf_cnt = 0;
	int char_errs = 0;
	int count_errs = 0;
	int timeouts = 0;
	logic aborted = 1'b0;
	int s;

	ps2_keyboard uut (.*);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic step_t make_step(input logic [95:0] seq, input int len,
		input logic [11:0] bad, input logic [15:0] chars, input int n_chars,
		input int n_ferr, input int n_ovf, input logic hold);
		step_t st;
		st = '{seq: seq, len: 4'(len), bad: bad, chars: chars, n_chars: 2'(n_chars),
			n_ferr: 2'(n_ferr), n_ovf: 2'(n_ovf), hold: hold};
		return st;
	endfunction

	always @(posedge clk) begin
		rdy_rng = xorshift(rdy_rng);
		out_ready <= !hold_ready && (rdy_rng[1:0] != 2'b00); // about 3 of 4 cycles
	end

	always @(posedge clk) begin
		if (rstn && out_valid && out_ready) begin
			got_q.push_back(out_char);
		end
	end

	always @(posedge clk) begin
		if (rstn) begin
			ferr_cnt <= ferr_cnt + int'(frame_error);
			ovf_cnt  <= ovf_cnt + int'(overflow);
		end
	end

	// start, 8 data lsb first, odd parity, stop
	task automatic send_frame(input kbd_pkg::scan_code_t b, input logic flip);
		logic [10:0] bits;
		int i;
		bits = {1'b1, (~^b) ^ flip, b, 1'b0};
		for (i = 0; i < 11; i++) begin
			@(posedge clk);
			ps2_dat <= bits[i];
			repeat (5) @(posedge clk);
			ps2_clk <= 1'b0;
			repeat (6) @(posedge clk);
			ps2_clk <= 1'b1;
		end
	endtask

	task automatic wait_char(input int idx, input int n);
		int t;
		t = 0;
		while (got_q.size() == 0 && t < char_timeout) begin
			@(negedge clk);
			t++;
		end
		if (got_q.size() == 0) begin
			$display("timeout: step %0d never delivered character %0d", idx, n);
			timeouts++;
			aborted = 1'b1;
		end
	endtask

	task automatic check_char(input kbd_pkg::ascii_t got, input kbd_pkg::ascii_t exp,
		input int idx);
		if (got !== exp) begin
			$display("FAILED at %0t: step %0d expected char 0x%02h, got 0x%02h",
				$time, idx, exp, got);
			char_errs++;
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp, input int idx);
		if (got != exp) begin
			$display("FAILED at %0t: step %0d expected %0d %s pulses, got %0d",
				$time, idx, exp, what, got);
			count_errs++;
		end
	endtask

	task automatic run_step(input int idx);
		step_t st;
		int ferr0;
		int ovf0;
		int i;
		kbd_pkg::ascii_t exp_c;
		st = steps[idx];
		ferr0 = ferr_cnt;
		ovf0 = ovf_cnt;
		@(posedge clk);
		hold_ready <= st.hold;
		for (i = 0; i < int'(st.len); i++) begin
			send_frame(st.seq[8*(int'(st.len)-1-i) +: 8], st.bad[i]);
			gap_rng = xorshift(gap_rng);
			repeat (4 + int'(gap_rng[3:0])) @(posedge clk);
		end
		for (i = 0; i < int'(st.n_chars) && !aborted; i++) begin
			exp_c = st.chars[8*(int'(st.n_chars)-1-i) +: 8];
			wait_char(idx, i);
			if (!aborted) begin
				check_char(got_q.pop_front(), exp_c, idx);
			end
		end
		repeat (quiet_cycles) @(negedge clk);
		check_count("frame_error", ferr_cnt - ferr0, int'(st.n_ferr), idx);
		check_count("overflow", ovf_cnt - ovf0, int'(st.n_ovf), idx);
		// drain steps share the queued chars
		if ((idx == num_steps - 1 || steps[idx + 1].len != 0) && got_q.size() != 0) begin
			$display("FAILED at %0t: step %0d left %0d extra characters",
				$time, idx, got_q.size());
			char_errs++;
			got_q.delete();
		end
	endtask

	initial begin
		rstn = 1'b0;
		ps2_clk = 1'b1;
		ps2_dat = 1'b1;
		steps[0]  = make_step(96'h1C_F0_1C, 3, 12'h000, "a", 1, 0, 0, 1'b0);
		steps[1]  = make_step(96'h1A_F0_1A_2E_F0_2E, 6, 12'h000, "z5", 2, 0, 0, 1'b0);
		steps[2]  = make_step(96'h29_F0_29_5A_F0_5A, 6, 12'h000, 16'h200D, 2, 0, 0, 1'b0);
		steps[3]  = make_step(96'h12_1C_F0_1C, 4, 12'h000, "A", 1, 0, 0, 1'b0);
		steps[4]  = make_step(96'h26_F0_26, 3, 12'h000, "#", 1, 0, 0, 1'b0);
		steps[5]  = make_step(96'hF0_12_1C_F0_1C, 5, 12'h000, "a", 1, 0, 0, 1'b0);
		steps[6]  = make_step(96'h59_1C_F0_1C_26_F0_26, 7, 12'h000, "A#", 2, 0, 0, 1'b0);
		steps[7]  = make_step(96'hF0_59_1C_F0_1C, 5, 12'h000, "a", 1, 0, 0, 1'b0);
		steps[8]  = make_step(96'hE0_75_E0_F0_75_E0_72_E0_F0_72, 10, 12'h000, 16'h0102,
			2, 0, 0, 1'b0);
		steps[9]  = make_step(96'hE0_6B_E0_F0_6B_E0_74_E0_F0_74, 10, 12'h000, 16'h0304,
			2, 0, 0, 1'b0);
		steps[10] = make_step(96'h2B_2B_2B_F0_2B_2B_F0_2B, 8, 12'h000, "ff", 2, 0, 0, 1'b0);
		steps[11] = make_step(96'h24_34_F0_34, 4, 12'h001, "g", 1, 1, 0, 1'b0); // bad 'e'
		steps[12] = make_step(96'h15_F0_15_1D_F0_1D_24_F0_24_2D_F0_2D, 12, 12'h000, 0,
			0, 0, 0, 1'b1);
		steps[13] = make_step(96'h2C_F0_2C_35_F0_35_3C_F0_3C_43_F0_43, 12, 12'h000, 0,
			0, 0, 0, 1'b1);
		steps[14] = make_step(96'h44_F0_44_4D_F0_4D, 6, 12'h000, 0, 0, 0, 2, 1'b1); // full
		steps[15] = make_step(0, 0, 12'h000, "qw", 2, 0, 0, 1'b0);
		steps[16] = make_step(0, 0, 12'h000, "er", 2, 0, 0, 1'b0);
		steps[17] = make_step(0, 0, 12'h000, "ty", 2, 0, 0, 1'b0);
		steps[18] = make_step(0, 0, 12'h000, "ui", 2, 0, 0, 1'b0);
		steps[19] = make_step(96'h45_F0_45, 3, 12'h000, "0", 1, 0, 0, 1'b0);
		repeat (5) @(posedge clk);
		rstn <= 1'b1;
		repeat (4) @(posedge clk);
		for (s = 0; s < num_steps && !aborted; s++) begin
			run_step(s);
		end
		$display("errors: %0d character, %0d count, %0d timeout, %0d assertion",
			char_errs, count_errs, timeouts, uut.u_props.fail_count);
		if (char_errs == 0 && count_errs == 0 && timeouts == 0
			&& uut.u_props.fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
